// File: logic/icache_geom_pkg.sv
// instruction cache geometry
// address split, set and way counts, and the stored payload types
package icache_geom_pkg;

    // fetch address and instruction word
    localparam int ADDR_W = 64;
    localparam int WORD_W = 32;

    // 64 sets, index taken from address bits 8..3
    localparam int SETS      = 64;
    localparam int INDEX_W   = 6;
    localparam int INDEX_LSB = 3;

    // tag is everything above the index
    localparam int TAG_W = ADDR_W - INDEX_W - INDEX_LSB;

    localparam int WAYS = 2;

    // tag entry held per way and set
    typedef logic [TAG_W-1:0] tag_t;

    // one instruction word per 8-byte granule
    typedef logic [WORD_W-1:0] word_t;

endpackage

// File: logic/icache_state_pkg.sv
// instruction cache control encodings
// fetch FSM states and replacement age counter limits
package icache_state_pkg;

    // one-hot controller states
    typedef enum logic [3:0] {
        IDLE    = 4'b0001,
        LOOKUP  = 4'b0010,
        REFILL  = 4'b0100,
        RESPOND = 4'b1000
    } state_t;

    // per-way age counter, saturating
    localparam int AGE_W = 3;
    localparam logic [AGE_W-1:0] AGE_MAX = 3'd7;

endpackage

// File: logic/icache_way_ram.sv
// icache way storage
// one entry per set, registered read port and a single write port
`timescale 1ns/1ps

module icache_way_ram #(
    parameter type payload_t = logic
) (
    input  logic                                 clk,
    input  logic [icache_geom_pkg::INDEX_W-1:0]  i_rd_index,
    input  logic                                 i_wr_ena,
    input  logic [icache_geom_pkg::INDEX_W-1:0]  i_wr_index,
    input  payload_t                             i_wr_data,
    output payload_t                             o_rd_data
);

    payload_t mem [icache_geom_pkg::SETS];

    always_ff @(posedge clk) begin
        if (i_wr_ena) begin
            mem[i_wr_index] <= i_wr_data;
        end
    end

    // read data shows up one cycle after the index
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_index];
    end

endmodule

// File: logic/icache_replace.sv
// icache replacement state
// per-set valid bits and saturating age counters for both ways,
// victim selection for the set currently being served
`timescale 1ns/1ps

module icache_replace (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [icache_geom_pkg::INDEX_W-1:0]  i_index,
    input  logic                                 i_accept,
    input  logic                                 i_touch,
    input  logic                                 i_touch_way,
    input  logic                                 i_fill,
    input  logic                                 i_fill_way,
    output logic [icache_geom_pkg::WAYS-1:0]     o_valid,
    output logic                                 o_victim_way
);

    logic [icache_geom_pkg::WAYS-1:0]       valid_q [icache_geom_pkg::SETS];
    logic [icache_state_pkg::AGE_W-1:0]     age_q   [icache_geom_pkg::SETS][icache_geom_pkg::WAYS];

    logic [icache_state_pkg::AGE_W-1:0]     age0;
    logic [icache_state_pkg::AGE_W-1:0]     age1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < icache_geom_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else begin
            // every accepted fetch ages the whole cache
            if (i_accept) begin
                for (int s = 0; s < icache_geom_pkg::SETS; s++) begin
                    for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
                        if (age_q[s][w] != icache_state_pkg::AGE_MAX) begin
                            age_q[s][w] <= age_q[s][w] + 1'b1;
                        end
                    end
                end
            end
            // a clear wins over aging in the same cycle
            if (i_touch) begin
                age_q[i_index][i_touch_way] <= '0;
            end
            if (i_fill) begin
                age_q[i_index][i_fill_way]   <= '0;
                valid_q[i_index][i_fill_way] <= 1'b1;
            end
        end
    end

    assign o_valid = valid_q[i_index];
    assign age0    = age_q[i_index][0];
    assign age1    = age_q[i_index][1];

    // empty way first, then the older one, tie to way 0
    always_comb begin
        if (!o_valid[0]) begin
            o_victim_way = 1'b0;
        end else if (!o_valid[1]) begin
            o_victim_way = 1'b1;
        end else if (age1 > age0) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = 1'b0;
        end
    end

endmodule

// File: logic/icache_ctrl.sv
// icache fetch controller
// accepts one fetch at a time, compares tags, runs the refill from
// memory on a miss and presents the word for one cycle
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_inst_ena,
    input  logic [icache_geom_pkg::ADDR_W-1:0]   i_inst_addr,
    input  icache_geom_pkg::word_t               i_mem_data,
    input  logic                                 i_mem_ok,
    input  icache_geom_pkg::tag_t                i_tag0,
    input  icache_geom_pkg::tag_t                i_tag1,
    input  icache_geom_pkg::word_t               i_word0,
    input  icache_geom_pkg::word_t               i_word1,
    input  logic [icache_geom_pkg::WAYS-1:0]     i_valid,
    input  logic                                 i_victim_way,
    output logic                                 o_inst_valid,
    output icache_geom_pkg::word_t               o_inst_data,
    output logic                                 o_busy,
    output logic                                 o_mem_read_ena,
    output logic [icache_geom_pkg::ADDR_W-1:0]   o_mem_addr,
    output logic [icache_geom_pkg::INDEX_W-1:0]  o_rd_index,
    output logic [icache_geom_pkg::INDEX_W-1:0]  o_wr_index,
    output logic [icache_geom_pkg::WAYS-1:0]     o_tag_wr_ena,
    output logic [icache_geom_pkg::WAYS-1:0]     o_word_wr_ena,
    output icache_geom_pkg::tag_t                o_wr_tag,
    output icache_geom_pkg::word_t               o_wr_word,
    output logic                                 o_accept,
    output logic                                 o_touch,
    output logic                                 o_touch_way,
    output logic                                 o_fill,
    output logic                                 o_fill_way
);

    icache_state_pkg::state_t state_q;
    icache_state_pkg::state_t state_d;

    icache_geom_pkg::tag_t                  cap_tag_q;
    logic [icache_geom_pkg::INDEX_W-1:0]    cap_index_q;
    icache_geom_pkg::word_t                 resp_data_q;
    logic                                   resp_hit_q;
    logic                                   hit_way_q;

    logic                                   busy;
    logic                                   accept;
    logic                                   hit0;
    logic                                   hit1;
    logic                                   hit;
    logic                                   fill;

    // new fetches are taken in IDLE and in the response cycle
    assign busy   = (state_q == icache_state_pkg::LOOKUP) ||
                    (state_q == icache_state_pkg::REFILL);
    assign accept = i_inst_ena && !busy;

    // tag compare against the RAM outputs of the captured set
    assign hit0 = i_valid[0] && (i_tag0 == cap_tag_q);
    assign hit1 = i_valid[1] && (i_tag1 == cap_tag_q);
    assign hit  = hit0 || hit1;

    assign fill = (state_q == icache_state_pkg::REFILL) && i_mem_ok;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_state_pkg::IDLE: begin
                if (accept) begin
                    state_d = icache_state_pkg::LOOKUP;
                end
            end
            icache_state_pkg::LOOKUP: begin
                if (hit) begin
                    state_d = icache_state_pkg::RESPOND;
                end else begin
                    state_d = icache_state_pkg::REFILL;
                end
            end
            icache_state_pkg::REFILL: begin
                if (i_mem_ok) begin
                    state_d = icache_state_pkg::RESPOND;
                end
            end
            icache_state_pkg::RESPOND: begin
                // back-to-back fetch goes straight to lookup
                if (accept) begin
                    state_d = icache_state_pkg::LOOKUP;
                end else begin
                    state_d = icache_state_pkg::IDLE;
                end
            end
            default: begin
                state_d = icache_state_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= icache_state_pkg::IDLE;
            resp_hit_q <= 1'b0;
            hit_way_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == icache_state_pkg::LOOKUP) begin
                resp_hit_q <= hit;
                // way 0 wins if both match
                hit_way_q  <= hit1 && !hit0;
            end
        end
    end

    // captured address and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_tag_q   <= i_inst_addr[icache_geom_pkg::ADDR_W-1 -: icache_geom_pkg::TAG_W];
            cap_index_q <= i_inst_addr[icache_geom_pkg::INDEX_LSB +: icache_geom_pkg::INDEX_W];
        end
        if ((state_q == icache_state_pkg::LOOKUP) && hit) begin
            resp_data_q <= hit0 ? i_word0 : i_word1;
        end else if (fill) begin
            resp_data_q <= i_mem_data;
        end
    end

    // core side
    assign o_busy       = busy;
    assign o_inst_valid = (state_q == icache_state_pkg::RESPOND);
    assign o_inst_data  = resp_data_q;

    // memory side, granule aligned
    assign o_mem_read_ena = (state_q == icache_state_pkg::REFILL);
    assign o_mem_addr     = {cap_tag_q, cap_index_q, {icache_geom_pkg::INDEX_LSB{1'b0}}};

    // RAM addressing
    assign o_rd_index = busy ? cap_index_q
                             : i_inst_addr[icache_geom_pkg::INDEX_LSB +: icache_geom_pkg::INDEX_W];
    assign o_wr_index = cap_index_q;

    // victim way is written when memory answers
    assign o_tag_wr_ena  = {fill && i_victim_way, fill && !i_victim_way};
    assign o_word_wr_ena = {fill && i_victim_way, fill && !i_victim_way};
    assign o_wr_tag      = cap_tag_q;
    assign o_wr_word     = i_mem_data;

    // replacement updates
    assign o_accept    = accept;
    assign o_touch     = (state_q == icache_state_pkg::RESPOND) && resp_hit_q;
    assign o_touch_way = hit_way_q;
    assign o_fill      = fill;
    assign o_fill_way  = i_victim_way;

endmodule

// File: logic/icache_top.sv
// two-way set-associative instruction cache
// controller, replacement state and separate tag and word arrays per way
`timescale 1ns/1ps

module icache_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_inst_ena,
    input  logic [icache_geom_pkg::ADDR_W-1:0]   i_inst_addr,
    output logic                                 o_inst_valid,
    output logic [icache_geom_pkg::WORD_W-1:0]   o_inst_data,
    output logic                                 o_busy,
    output logic                                 o_mem_read_ena,
    output logic [icache_geom_pkg::ADDR_W-1:0]   o_mem_addr,
    input  logic [icache_geom_pkg::WORD_W-1:0]   i_mem_data,
    input  logic                                 i_mem_ok
);

    logic [icache_geom_pkg::INDEX_W-1:0]    rd_index;
    logic [icache_geom_pkg::INDEX_W-1:0]    wr_index;
    logic [icache_geom_pkg::WAYS-1:0]       tag_wr_ena;
    logic [icache_geom_pkg::WAYS-1:0]       word_wr_ena;
    icache_geom_pkg::tag_t                  wr_tag;
    icache_geom_pkg::word_t                 wr_word;
    icache_geom_pkg::tag_t                  tag0;
    icache_geom_pkg::tag_t                  tag1;
    icache_geom_pkg::word_t                 word0;
    icache_geom_pkg::word_t                 word1;
    logic [icache_geom_pkg::WAYS-1:0]       valid;
    logic                                   victim_way;
    logic                                   accept;
    logic                                   touch;
    logic                                   touch_way;
    logic                                   fill;
    logic                                   fill_way;

    icache_ctrl u_icache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_inst_ena     (i_inst_ena),
        .i_inst_addr    (i_inst_addr),
        .i_mem_data     (i_mem_data),
        .i_mem_ok       (i_mem_ok),
        .i_tag0         (tag0),
        .i_tag1         (tag1),
        .i_word0        (word0),
        .i_word1        (word1),
        .i_valid        (valid),
        .i_victim_way   (victim_way),
        .o_inst_valid   (o_inst_valid),
        .o_inst_data    (o_inst_data),
        .o_busy         (o_busy),
        .o_mem_read_ena (o_mem_read_ena),
        .o_mem_addr     (o_mem_addr),
        .o_rd_index     (rd_index),
        .o_wr_index     (wr_index),
        .o_tag_wr_ena   (tag_wr_ena),
        .o_word_wr_ena  (word_wr_ena),
        .o_wr_tag       (wr_tag),
        .o_wr_word      (wr_word),
        .o_accept       (accept),
        .o_touch        (touch),
        .o_touch_way    (touch_way),
        .o_fill         (fill),
        .o_fill_way     (fill_way)
    );

    // ages and valid bits follow the captured set
    icache_replace u_icache_replace (
        .clk          (clk),
        .rst          (rst),
        .i_index      (wr_index),
        .i_accept     (accept),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .i_fill       (fill),
        .i_fill_way   (fill_way),
        .o_valid      (valid),
        .o_victim_way (victim_way)
    );

    icache_way_ram #(.payload_t(icache_geom_pkg::tag_t)) u_tag_way0 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_ena   (tag_wr_ena[0]),
        .i_wr_index (wr_index),
        .i_wr_data  (wr_tag),
        .o_rd_data  (tag0)
    );

    icache_way_ram #(.payload_t(icache_geom_pkg::tag_t)) u_tag_way1 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_ena   (tag_wr_ena[1]),
        .i_wr_index (wr_index),
        .i_wr_data  (wr_tag),
        .o_rd_data  (tag1)
    );

    icache_way_ram #(.payload_t(icache_geom_pkg::word_t)) u_word_way0 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_ena   (word_wr_ena[0]),
        .i_wr_index (wr_index),
        .i_wr_data  (wr_word),
        .o_rd_data  (word0)
    );

    icache_way_ram #(.payload_t(icache_geom_pkg::word_t)) u_word_way1 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_ena   (word_wr_ena[1]),
        .i_wr_index (wr_index),
        .i_wr_data  (wr_word),
        .o_rd_data  (word1)
    );

endmodule

// File: testbench/icache_mem_model.sv
// backing memory responder for the icache testbench
// answers each rising read request with one ok pulse after a set delay
`timescale 1ns/1ps

module icache_mem_model #(
    parameter logic [31:0] SCRAMBLE = 32'h0
) (
    input  logic        clk,
    input  logic [2:0]  i_delay,
    input  logic        i_read_ena,
    input  logic [63:0] i_addr,
    output logic [31:0] o_data,
    output logic        o_ok,
    output int          o_read_count
);

    logic read_q;
    logic start;
    logic pending;
    int   wait_cnt;

    initial begin
        o_ok         = 1'b0;
        o_data       = '0;
        o_read_count = 0;
        read_q       = 1'b0;
        pending      = 1'b0;
        wait_cnt     = 0;
        forever begin
            @(posedge clk);
            start  = i_read_ena && !read_q;
            read_q = i_read_ena;
            #1;
            o_ok = 1'b0;
            if (start) begin
                pending  = 1'b1;
                wait_cnt = int'(i_delay);
                o_read_count++;
            end
            if (pending) begin
                if (wait_cnt == 0) begin
                    // word derived from the granule address
                    o_ok    = 1'b1;
                    o_data  = i_addr[34:3] ^ SCRAMBLE;
                    pending = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

// File: testbench/icache_tb.sv
// icache testbench
// directed fetch tests checked against a reference model of the cache
`timescale 1ns/1ps

module icache_tb;

    localparam logic [31:0] SEED           = 32'h52f0_8265;
    localparam logic [31:0] SCRAMBLE       = 32'h9e37_79b9;
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam int          FETCH_LIMIT    = 40;

    logic        clk;
    logic        rst;
    logic        inst_ena;
    logic [63:0] inst_addr;
    logic        o_inst_valid;
    logic [31:0] o_inst_data;
    logic        o_busy;
    logic        o_mem_read_ena;
    logic [63:0] o_mem_addr;
    logic [31:0] mem_data;
    logic        mem_ok;
    logic [2:0]  mem_delay;
    int          read_count;
    int          errors;
    int          cycles;
    logic [31:0] rng;

    // reference model state
    logic [54:0] m_tag   [64][2];
    bit          m_valid [64][2];
    int          m_age   [64][2];

    icache_top u_icache_top (
        .clk            (clk),
        .rst            (rst),
        .i_inst_ena     (inst_ena),
        .i_inst_addr    (inst_addr),
        .o_inst_valid   (o_inst_valid),
        .o_inst_data    (o_inst_data),
        .o_busy         (o_busy),
        .o_mem_read_ena (o_mem_read_ena),
        .o_mem_addr     (o_mem_addr),
        .i_mem_data     (mem_data),
        .i_mem_ok       (mem_ok)
    );

    icache_mem_model #(.SCRAMBLE(SCRAMBLE)) u_mem (
        .clk          (clk),
        .i_delay      (mem_delay),
        .i_read_ena   (o_mem_read_ena),
        .i_addr       (o_mem_addr),
        .o_data       (mem_data),
        .o_ok         (mem_ok),
        .o_read_count (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped, no finish after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // age, then hit or fill, same order as the cache applies them
    task automatic predict(input logic [63:0] addr, output bit hit,
                           output logic [31:0] data);
        logic [5:0]  idx;
        logic [54:0] tg;
        int          way;
        idx = addr[8:3];
        tg  = addr[63:9];
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_age[s][w] < 7) begin
                    m_age[s][w]++;
                end
            end
        end
        hit = 1'b1;
        if (m_valid[idx][0] && m_tag[idx][0] == tg) begin
            way = 0;
        end else if (m_valid[idx][1] && m_tag[idx][1] == tg) begin
            way = 1;
        end else begin
            hit = 1'b0;
            if (!m_valid[idx][0]) begin
                way = 0;
            end else if (!m_valid[idx][1]) begin
                way = 1;
            end else begin
                way = (m_age[idx][1] > m_age[idx][0]) ? 1 : 0;
            end
            m_tag[idx][way]   = tg;
            m_valid[idx][way] = 1'b1;
        end
        m_age[idx][way] = 0;
        data = addr[34:3] ^ SCRAMBLE;
    endtask

    task automatic run_fetch(input logic [63:0] addr, input logic [2:0] delay,
                             input bit strobe_busy, output bit was_miss);
        bit          exp_hit;
        logic [31:0] exp_data;
        logic [31:0] data;
        int          cyc;
        int          lat;
        int          ok_cyc;
        int          valids;
        int          reads_before;
        predict(addr, exp_hit, exp_data);
        reads_before = read_count;
        mem_delay    = delay;
        inst_addr    = addr;
        inst_ena     = 1'b1;
        cyc          = 0;
        lat          = 0;
        ok_cyc       = -1;
        valids       = 0;
        was_miss     = 1'b0;
        data         = '0;
        while (valids == 0 && cyc < FETCH_LIMIT) begin
            tick();
            cyc++;
            // a second strobe during the refill must be dropped
            inst_ena = strobe_busy && (cyc == 2);
            if (strobe_busy && cyc == 2) begin
                inst_addr = addr ^ 64'h1000;
            end
            #1;
            if (o_mem_read_ena && !was_miss) begin
                was_miss = 1'b1;
                if (o_mem_addr != {addr[63:3], 3'b000}) begin
                    report_value("o_mem_addr", {addr[63:3], 3'b000}, o_mem_addr);
                end
            end
            if (mem_ok) begin
                ok_cyc = cyc;
            end
            if (o_inst_valid) begin
                valids++;
                lat  = cyc;
                data = o_inst_data;
                // idle again in the response cycle
                if (o_busy) begin
                    report_value("o_busy", 64'(0), 64'(o_busy));
                end
            end else if (!o_busy) begin
                $display("o_busy low at %0t while fetch of %h is in flight", $time, addr);
                errors++;
            end
        end
        if (valids == 0) begin
            $display("fetch of %h got no response within %0d cycles", addr, FETCH_LIMIT);
            errors++;
        end
        if (data !== exp_data) begin
            report_value("o_inst_data", 64'(exp_data), 64'(data));
        end
        if (was_miss == exp_hit) begin
            report_value("o_mem_read_ena", 64'(!exp_hit), 64'(was_miss));
        end
        if (read_count - reads_before != (exp_hit ? 0 : 1)) begin
            $display("memory saw %0d reads for fetch of %h", read_count - reads_before, addr);
            errors++;
        end
        if (exp_hit && lat != 2) begin
            report_value("hit latency", 64'(2), 64'(lat));
        end
        if (!exp_hit && lat != ok_cyc + 1) begin
            report_value("miss latency", 64'(ok_cyc + 1), 64'(lat));
        end
        tick();
        if (o_inst_valid) begin
            $display("extra o_inst_valid pulse after fetch of %h", addr);
            errors++;
        end
        if (o_busy) begin
            report_value("o_busy", 64'(0), 64'(o_busy));
        end
    endtask

    task automatic reset_outputs();
        repeat (5) @(posedge clk);
        if (o_inst_valid || o_busy || o_mem_read_ena) begin
            $display("outputs not low during reset");
            errors++;
        end
        #1;
        rst = 1'b1;
        tick();
        if (o_inst_valid || o_busy || o_mem_read_ena) begin
            $display("outputs not low after reset");
            errors++;
        end
    endtask

    task automatic miss_then_hit();
        bit miss;
        run_fetch(64'h0000_1234_5678_0008, 3'd3, 1'b0, miss);
        run_fetch(64'h0000_1234_5678_000d, 3'd0, 1'b0, miss);
    endtask

    task automatic older_way_replaced();
        logic [63:0] addrs [6];
        bit          pattern [6];
        bit          miss;
        // tags A, B, A, C, A, B in set 5
        addrs   = '{64'h228, 64'h428, 64'h228, 64'h628, 64'h228, 64'h428};
        pattern = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
        for (int k = 0; k < 6; k++) begin
            run_fetch(addrs[k], 3'd1, 1'b0, miss);
            if (miss != pattern[k]) begin
                report_value("o_mem_read_ena", 64'(pattern[k]), 64'(miss));
            end
        end
    endtask

    task automatic busy_strobe_ignored();
        bit miss;
        run_fetch(64'h0000_0000_0000_4010, 3'd6, 1'b1, miss);
    endtask

    task automatic random_stream();
        int          g;
        logic [63:0] addr;
        bit          miss;
        // 12 granules, three tags in each of sets 8 to 11
        for (int i = 0; i < 300; i++) begin
            rng  = xorshift32(rng);
            g    = int'(rng % 32'd12);
            addr = (64'(g / 4 + 7) << 9) | (64'(8 + g % 4) << 3) | 64'(rng[18:16]);
            run_fetch(addr, rng[10:8], 1'b0, miss);
        end
    endtask

    initial begin
        rst        = 1'b0;
        inst_ena   = 1'b0;
        inst_addr  = '0;
        mem_delay  = '0;
        errors     = 0;
        cycles     = 0;
        rng        = SEED;
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
        reset_outputs();
        miss_then_hit();
        older_way_replaced();
        busy_strobe_ignored();
        random_stream();
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: icache.f
logic/icache_geom_pkg.sv
logic/icache_state_pkg.sv
logic/icache_way_ram.sv
logic/icache_replace.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f icache.f \
    --top-module icache_tb \
    --Mdir obj_dir \
    -o icache_sim

./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "icache simulation passed"
    exit 0
else
    echo "icache simulation failed"
    exit 1
fi
